/* common/vmul_defs.svh */
`ifndef VMUL_DEFS_SVH
`define VMUL_DEFS_SVH

// vector and request widths
`define VMUL_DATA_W 64
`define VMUL_ADDR_W 32

// operand slots, one extension bit plus margin
`define VMUL_SLOT_W 18
`define VMUL_WORD_W 33

`define VMUL_LATENCY 3
`define VMUL_SLICES 4

`endif

/* common/vmul_pkg.sv */
`default_nettype none

package vmul_pkg;

	// element width; sew_64 is reserved and yields zero
	typedef enum logic [1:0] {
		sew_8  = 2'b00,
		sew_16 = 2'b01,
		sew_32 = 2'b10,
		sew_64 = 2'b11
	} sew_e;

	// low two bits of the vector multiply funct3
	typedef enum logic [1:0] {
		op_mulhu  = 2'b00,
		op_mul    = 2'b01,
		op_mulhsu = 2'b10,
		op_mulh   = 2'b11
	} mul_op_e;

endpackage

`default_nettype wire

/* common/mul_stage_if.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

// extended operands for each slice, stage 1 to stage 2
interface operand_if;
	import vmul_pkg::*;

	logic                           valid;
	sew_e                           sew;
	mul_op_e                        op;
	logic [`VMUL_ADDR_W-1:0]        addr;
	logic signed [`VMUL_SLOT_W-1:0] a0 [`VMUL_SLICES];
	logic signed [`VMUL_SLOT_W-1:0] b0 [`VMUL_SLICES];
	logic signed [`VMUL_SLOT_W-1:0] a1 [`VMUL_SLICES];
	logic signed [`VMUL_SLOT_W-1:0] b1 [`VMUL_SLICES];
	logic signed [`VMUL_WORD_W-1:0] aw [`VMUL_SLICES];
	logic signed [`VMUL_WORD_W-1:0] bw [`VMUL_SLICES];

	modport src (output valid, sew, op, addr, a0, b0, a1, b1, aw, bw);
	modport dst (input valid, sew, op, addr, a0, b0, a1, b1, aw, bw);
endinterface

// full-width products, stage 2 to stage 3
interface product_if;
	import vmul_pkg::*;

	logic                             valid;
	sew_e                             sew;
	mul_op_e                          op;
	logic [`VMUL_ADDR_W-1:0]          addr;
	logic signed [2*`VMUL_SLOT_W-1:0] p0 [`VMUL_SLICES];
	logic signed [2*`VMUL_SLOT_W-1:0] p1 [`VMUL_SLICES];
	logic signed [2*`VMUL_WORD_W-1:0] pw [`VMUL_SLICES];

	modport src (output valid, sew, op, addr, p0, p1, pw);
	modport dst (input valid, sew, op, addr, p0, p1, pw);
endinterface

`default_nettype wire

/* rtl/operand_select.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

module operand_select (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`VMUL_DATA_W-1:0] a_vec,
	input  logic [`VMUL_DATA_W-1:0] b_vec,
	input  logic                    req_valid,
	input  vmul_pkg::sew_e          req_sew,
	input  vmul_pkg::mul_op_e       req_op,
	input  logic [`VMUL_ADDR_W-1:0] req_addr,
	operand_if.src                  opnd
);
	import vmul_pkg::*;

	localparam int BYTES  = `VMUL_DATA_W / 8;
	localparam int HALVES = `VMUL_DATA_W / 16;
	localparam int WORDS  = `VMUL_DATA_W / 32;

	logic a_sgn;
	logic b_sgn;
	logic signed [`VMUL_SLOT_W-1:0] a0_n [`VMUL_SLICES];
	logic signed [`VMUL_SLOT_W-1:0] b0_n [`VMUL_SLICES];
	logic signed [`VMUL_SLOT_W-1:0] a1_n [`VMUL_SLICES];
	logic signed [`VMUL_SLOT_W-1:0] b1_n [`VMUL_SLICES];
	logic signed [`VMUL_WORD_W-1:0] aw_n [`VMUL_SLICES];
	logic signed [`VMUL_WORD_W-1:0] bw_n [`VMUL_SLICES];

	function automatic logic signed [`VMUL_SLOT_W-1:0] ext_byte(input logic [7:0] e,
			input logic sgn);
		return {{(`VMUL_SLOT_W-8){sgn & e[7]}}, e};
	endfunction

	function automatic logic signed [`VMUL_SLOT_W-1:0] ext_half(input logic [15:0] e,
			input logic sgn);
		return {{(`VMUL_SLOT_W-16){sgn & e[15]}}, e};
	endfunction

	function automatic logic signed [`VMUL_WORD_W-1:0] ext_word(input logic [31:0] e,
			input logic sgn);
		return {{(`VMUL_WORD_W-32){sgn & e[31]}}, e};
	endfunction

	// low half of op_mul does not care, so it takes the signed path
	assign a_sgn = (req_op != op_mulhu);
	assign b_sgn = (req_op == op_mul) || (req_op == op_mulh);

	always_comb begin
		a0_n = '{default: '0};
		b0_n = '{default: '0};
		a1_n = '{default: '0};
		b1_n = '{default: '0};
		aw_n = '{default: '0};
		bw_n = '{default: '0};
		case (req_sew)
			sew_8: begin
				// two bytes share a slice
				for (int k = 0; k < BYTES; k++) begin
					if (k % 2 == 0) begin
						a0_n[k/2] = ext_byte(a_vec[8*k +: 8], a_sgn);
						b0_n[k/2] = ext_byte(b_vec[8*k +: 8], b_sgn);
					end else begin
						a1_n[k/2] = ext_byte(a_vec[8*k +: 8], a_sgn);
						b1_n[k/2] = ext_byte(b_vec[8*k +: 8], b_sgn);
					end
				end
			end
			sew_16: begin
				for (int k = 0; k < HALVES; k++) begin
					a0_n[k] = ext_half(a_vec[16*k +: 16], a_sgn);
					b0_n[k] = ext_half(b_vec[16*k +: 16], b_sgn);
				end
			end
			sew_32: begin
				for (int k = 0; k < WORDS; k++) begin
					aw_n[k] = ext_word(a_vec[32*k +: 32], a_sgn);
					bw_n[k] = ext_word(b_vec[32*k +: 32], b_sgn);
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || !req_valid) begin
			opnd.valid <= 1'b0;
			opnd.sew   <= sew_8;
			opnd.op    <= op_mulhu;
			opnd.addr  <= '0;
			opnd.a0    <= '{default: '0};
			opnd.b0    <= '{default: '0};
			opnd.a1    <= '{default: '0};
			opnd.b1    <= '{default: '0};
			opnd.aw    <= '{default: '0};
			opnd.bw    <= '{default: '0};
		end else begin
			opnd.valid <= 1'b1;
			opnd.sew   <= req_sew;
			opnd.op    <= req_op;
			opnd.addr  <= req_addr;
			opnd.a0    <= a0_n;
			opnd.b0    <= b0_n;
			opnd.a1    <= a1_n;
			opnd.b1    <= b1_n;
			opnd.aw    <= aw_n;
			opnd.bw    <= bw_n;
		end
	end

endmodule

`default_nettype wire

/* mult_array/slice_mult.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

module slice_mult (
	input  logic                             clk,
	input  logic                             rst,
	input  logic signed [`VMUL_SLOT_W-1:0]   a0,
	input  logic signed [`VMUL_SLOT_W-1:0]   b0,
	input  logic signed [`VMUL_SLOT_W-1:0]   a1,
	input  logic signed [`VMUL_SLOT_W-1:0]   b1,
	input  logic signed [`VMUL_WORD_W-1:0]   aw,
	input  logic signed [`VMUL_WORD_W-1:0]   bw,
	output logic signed [2*`VMUL_SLOT_W-1:0] p0,
	output logic signed [2*`VMUL_SLOT_W-1:0] p1,
	output logic signed [2*`VMUL_WORD_W-1:0] pw
);

	// narrow pairs fit one 18x18 DSP each, word pair takes a cascade
	always_ff @(posedge clk) begin
		if (rst) begin
			p0 <= '0;
			p1 <= '0;
			pw <= '0;
		end else begin
			p0 <= a0 * b0;
			p1 <= a1 * b1;
			pw <= aw * bw;
		end
	end

endmodule

`default_nettype wire

/* mult_array/mult_array.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

module mult_array (
	input  logic   clk,
	input  logic   rst,
	operand_if.dst opnd,
	product_if.src prod
);
	import vmul_pkg::*;

	for (genvar g = 0; g < `VMUL_SLICES; g++) begin : g_slice
		slice_mult u_slice (
			.clk (clk),
			.rst (rst),
			.a0  (opnd.a0[g]),
			.b0  (opnd.b0[g]),
			.a1  (opnd.a1[g]),
			.b1  (opnd.b1[g]),
			.aw  (opnd.aw[g]),
			.bw  (opnd.bw[g]),
			.p0  (prod.p0[g]),
			.p1  (prod.p1[g]),
			.pw  (prod.pw[g])
		);
	end

	// request fields, one stage to match the product registers
	always_ff @(posedge clk) begin
		if (rst) begin
			prod.valid <= 1'b0;
			prod.sew   <= sew_8;
			prod.op    <= op_mulhu;
			prod.addr  <= '0;
		end else begin
			prod.valid <= opnd.valid;
			prod.sew   <= opnd.sew;
			prod.op    <= opnd.op;
			prod.addr  <= opnd.addr;
		end
	end

endmodule

`default_nettype wire

/* rtl/result_select.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

module result_select (
	input  logic                    clk,
	input  logic                    rst,
	product_if.dst                  prod,
	output logic [`VMUL_DATA_W-1:0] res_vec,
	output logic                    res_valid,
	output logic [`VMUL_ADDR_W-1:0] res_addr
);
	import vmul_pkg::*;

	localparam int BYTES  = `VMUL_DATA_W / 8;
	localparam int HALVES = `VMUL_DATA_W / 16;
	localparam int WORDS  = `VMUL_DATA_W / 32;

	logic                    hi;
	logic [`VMUL_DATA_W-1:0] vec_n;

	// every op except op_mul returns the upper half
	assign hi = (prod.op != op_mul);

	always_comb begin
		vec_n = '0;
		case (prod.sew)
			sew_8: begin
				for (int k = 0; k < BYTES; k++) begin
					if (k % 2 == 0) begin
						vec_n[8*k +: 8] = hi ? prod.p0[k/2][15:8] : prod.p0[k/2][7:0];
					end else begin
						vec_n[8*k +: 8] = hi ? prod.p1[k/2][15:8] : prod.p1[k/2][7:0];
					end
				end
			end
			sew_16: begin
				for (int k = 0; k < HALVES; k++) begin
					vec_n[16*k +: 16] = hi ? prod.p0[k][31:16] : prod.p0[k][15:0];
				end
			end
			sew_32: begin
				for (int k = 0; k < WORDS; k++) begin
					vec_n[32*k +: 32] = hi ? prod.pw[k][63:32] : prod.pw[k][31:0];
				end
			end
			// reserved width
			default: vec_n = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			res_vec   <= '0;
			res_addr  <= '0;
		end else begin
			res_valid <= prod.valid;
			res_vec   <= vec_n;
			res_addr  <= prod.addr;
		end
	end

endmodule

`default_nettype wire

/* rtl/vmul_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

module vmul_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [`VMUL_DATA_W-1:0] a_vec,
	input  logic [`VMUL_DATA_W-1:0] b_vec,
	input  logic                    req_valid,
	input  vmul_pkg::sew_e          req_sew,
	input  vmul_pkg::mul_op_e       req_op,
	input  logic [`VMUL_ADDR_W-1:0] req_addr,
	output logic [`VMUL_DATA_W-1:0] res_vec,
	output logic                    res_valid,
	output logic [`VMUL_ADDR_W-1:0] res_addr
);

	operand_if opnd_if ();
	product_if prod_if ();

	// stage 1, slice and extend
	operand_select u_operand_select (
		.clk       (clk),
		.rst       (rst),
		.a_vec     (a_vec),
		.b_vec     (b_vec),
		.req_valid (req_valid),
		.req_sew   (req_sew),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.opnd      (opnd_if.src)
	);

	// stage 2, multiply
	mult_array u_mult_array (
		.clk  (clk),
		.rst  (rst),
		.opnd (opnd_if.dst),
		.prod (prod_if.src)
	);

	// stage 3, pick halves and pack
	result_select u_result_select (
		.clk       (clk),
		.rst       (rst),
		.prod      (prod_if.dst),
		.res_vec   (res_vec),
		.res_valid (res_valid),
		.res_addr  (res_addr)
	);

endmodule

`default_nettype wire

/* testbench/vmul_checker.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

module vmul_checker (
	input logic                    clk,
	input logic                    rst,
	input logic [`VMUL_DATA_W-1:0] a_vec,
	input logic [`VMUL_DATA_W-1:0] b_vec,
	input logic                    req_valid,
	input vmul_pkg::sew_e          req_sew,
	input vmul_pkg::mul_op_e       req_op,
	input logic [`VMUL_ADDR_W-1:0] req_addr,
	input logic [`VMUL_DATA_W-1:0] res_vec,
	input logic                    res_valid,
	input logic [`VMUL_ADDR_W-1:0] res_addr
);
	import vmul_pkg::*;

	int fail_count = 0;
	logic [`VMUL_DATA_W-1:0] exp_now;
	logic [`VMUL_DATA_W-1:0] exp_q [`VMUL_LATENCY];
	logic [`VMUL_ADDR_W-1:0] addr_q [`VMUL_LATENCY];
	logic                    valid_q [`VMUL_LATENCY];

	// extend each element and multiply modulo 2^64, then keep the requested half
	function automatic logic [63:0] lane_products(input logic [63:0] a, input logic [63:0] b,
			input sew_e sew, input mul_op_e op);
		int w;
		logic a_sgn;
		logic b_sgn;
		logic [63:0] mask;
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		logic [63:0] res;
		case (sew)
			sew_8:   w = 8;
			sew_16:  w = 16;
			sew_32:  w = 32;
			default: return 64'd0;
		endcase
		case (op)
			op_mulh: begin
				a_sgn = 1'b1;
				b_sgn = 1'b1;
			end
			op_mulhsu: begin
				a_sgn = 1'b1;
				b_sgn = 1'b0;
			end
			op_mulhu: begin
				a_sgn = 1'b0;
				b_sgn = 1'b0;
			end
			// low half is the same for any extension
			default: begin
				a_sgn = 1'b1;
				b_sgn = 1'b1;
			end
		endcase
		mask = (64'd1 << w) - 64'd1;
		res = 64'd0;
		for (int k = 0; k < 64 / w; k++) begin
			ea = (a >> (k * w)) & mask;
			eb = (b >> (k * w)) & mask;
			if (a_sgn && ea[w-1])
				ea = ea | ~mask;
			if (b_sgn && eb[w-1])
				eb = eb | ~mask;
			p = ea * eb;
			if (op != op_mul)
				p = p >> w;
			res = res | ((p & mask) << (k * w));
		end
		return res;
	endfunction

	assign exp_now = lane_products(a_vec, b_vec, req_sew, req_op);

	always_ff @(posedge clk) begin
		exp_q[0]   <= exp_now;
		addr_q[0]  <= req_addr;
		valid_q[0] <= req_valid;
		for (int i = 1; i < `VMUL_LATENCY; i++) begin
			exp_q[i]   <= exp_q[i-1];
			addr_q[i]  <= addr_q[i-1];
			valid_q[i] <= valid_q[i-1];
		end
	end

	valid_timing: assert property (@(posedge clk) disable iff (rst)
		res_valid == valid_q[`VMUL_LATENCY-1])
	else begin
		fail_count++;
		$error("Fail res_valid got %h expected %h", res_valid, valid_q[`VMUL_LATENCY-1]);
	end

	vec_value: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> res_vec == exp_q[`VMUL_LATENCY-1])
	else begin
		fail_count++;
		$error("Fail res_vec got %h expected %h", res_vec, exp_q[`VMUL_LATENCY-1]);
	end

	addr_value: assert property (@(posedge clk) disable iff (rst)
		res_valid |-> res_addr == addr_q[`VMUL_LATENCY-1])
	else begin
		fail_count++;
		$error("Fail res_addr got %h expected %h", res_addr, addr_q[`VMUL_LATENCY-1]);
	end

	// reserved width must come out as zero
	reserved_zero: assert property (@(posedge clk) disable iff (rst)
		res_valid && $past(req_sew, `VMUL_LATENCY) == sew_64 |-> res_vec == '0)
	else begin
		fail_count++;
		$error("Fail res_vec got %h expected %h", res_vec, 64'd0);
	end

endmodule

`default_nettype wire

/* testbench/vmul_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vmul_defs.svh"

module vmul_tb;
	import vmul_pkg::*;

	localparam int RANDOM_TESTS   = 300;
	localparam int DIRECTED_TESTS = 38;
	localparam int TEST_COUNT     = RANDOM_TESTS + DIRECTED_TESTS;
	// at most two cycles per request plus reset and drain
	localparam int CYCLE_LIMIT    = TEST_COUNT * 2 + 50;

	logic                    clk = 1'b0;
	logic                    rst;
	logic [`VMUL_DATA_W-1:0] a_vec;
	logic [`VMUL_DATA_W-1:0] b_vec;
	logic                    req_valid;
	sew_e                    req_sew;
	mul_op_e                 req_op;
	logic [`VMUL_ADDR_W-1:0] req_addr;
	logic [`VMUL_DATA_W-1:0] res_vec;
	logic                    res_valid;
	logic [`VMUL_ADDR_W-1:0] res_addr;

	int      seed = 32'hf451_c460;
	int      cycles = 0;
	int      errors;
	sew_e    sew_list [3] = '{sew_8, sew_16, sew_32};
	mul_op_e op_list [4] = '{op_mul, op_mulh, op_mulhu, op_mulhsu};

	vmul_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.a_vec     (a_vec),
		.b_vec     (b_vec),
		.req_valid (req_valid),
		.req_sew   (req_sew),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.res_vec   (res_vec),
		.res_valid (res_valid),
		.res_addr  (res_addr)
	);

	bind vmul_top vmul_checker chk0 (
		.clk       (clk),
		.rst       (rst),
		.a_vec     (a_vec),
		.b_vec     (b_vec),
		.req_valid (req_valid),
		.req_sew   (req_sew),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.res_vec   (res_vec),
		.res_valid (res_valid),
		.res_addr  (res_addr)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [63:0] most_negative(input sew_e s);
		case (s)
			sew_8:   return 64'h8080_8080_8080_8080;
			sew_16:  return 64'h8000_8000_8000_8000;
			default: return 64'h8000_0000_8000_0000;
		endcase
	endfunction

	task automatic send(input logic [63:0] a, input logic [63:0] b, input sew_e s,
			input mul_op_e o);
		@(negedge clk);
		a_vec     = a;
		b_vec     = b;
		req_sew   = s;
		req_op    = o;
		req_addr  = $random(seed);
		req_valid = 1'b1;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			req_valid = 1'b0;
		end
	endtask

	initial begin
		logic [31:0] rnd;
		rst       = 1'b1;
		a_vec     = '0;
		b_vec     = '0;
		req_valid = 1'b0;
		req_sew   = sew_8;
		req_op    = op_mul;
		req_addr  = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// corner elements sent back to back
		for (int s = 0; s < 3; s++) begin
			for (int o = 0; o < 4; o++) begin
				send(most_negative(sew_list[s]), most_negative(sew_list[s]),
					sew_list[s], op_list[o]);
				send('1, '1, sew_list[s], op_list[o]);
				send(most_negative(sew_list[s]), '1, sew_list[s], op_list[o]);
			end
		end
		idle(2);
		send(64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, sew_64, op_mul);
		send('1, '1, sew_64, op_mulhu);
		idle(1);

		// random mix with a gap before roughly one request in four
		for (int i = 0; i < RANDOM_TESTS; i++) begin
			rnd = $random(seed);
			if (rnd[5:4] == 2'b00)
				idle(1);
			send({$random(seed), $random(seed)}, {$random(seed), $random(seed)},
				sew_e'(rnd[1:0]), mul_op_e'(rnd[3:2]));
		end
		idle(`VMUL_LATENCY + 2);

		errors = dut0.chk0.fail_count;
		$display("run finished: %0d requests, %0d errors", TEST_COUNT, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/vmul_pkg.sv
common/mul_stage_if.sv
rtl/operand_select.sv
mult_array/slice_mult.sv
mult_array/mult_array.sv
rtl/result_select.sv
rtl/vmul_top.sv
testbench/vmul_checker.sv
testbench/vmul_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module vmul_tb -o vmul_sim \
	&& ./obj_dir/vmul_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "build or simulation ended with an error"
[ -f sim.log ] && cat sim.log
grep -q "^>>> PASS$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
